//--- source/barrel_pkg.sv
/*
	Barrel PC package
	Thread count, widths, clear and interrupt vector layout, shared types
	and the per-stage reset IDs of the eight-stage thread ring.
*/

package barrel_pkg;

	localparam int THREADS = 8;  // thread slots = ring stages
	localparam int ID_W    = 3;  // thread id width
	localparam int PC_W    = 16;  // program counter width
	localparam int DATA_W  = 16;  // test operand width

	typedef logic [ID_W-1:0]   id_t;  // thread id
	typedef logic [PC_W-1:0]   pc_t;  // program counter
	typedef logic [DATA_W-1:0] data_t;  // test operand

	typedef id_t [THREADS-1:0] id_ring_t;  // one id per stage
	typedef pc_t [THREADS-1:0] pc_ring_t;  // one pc per stage

	// clear vector = CLT_BASE + (id << CLT_SPAN)
	localparam pc_t CLT_BASE = 16'h0000;
	localparam int  CLT_SPAN = 12;  // 4k words per thread

	// interrupt vector = IRQ_BASE + (id << IRQ_SPAN)
	localparam pc_t IRQ_BASE = 16'h8000;
	localparam int  IRQ_SPAN = 12;

	// stage k holds thread k out of reset
	localparam id_ring_t ID_RST = {
		id_t'(7), id_t'(6), id_t'(5), id_t'(4),
		id_t'(3), id_t'(2), id_t'(1), id_t'(0)
	};

	// branch conditions, tested on operand a (and b)
	typedef enum logic [2:0] {
		ALWAYS = 3'd0,  // unconditional
		ZERO   = 3'd1,  // a == 0
		NZERO  = 3'd2,  // a != 0
		NEG    = 3'd3,  // a sign bit
		LT     = 3'd4,  // a < b, signed
		EQ     = 3'd5  // a == b
	} cond_e;

	// flow command for the slot at stage 0
	typedef struct packed {
		logic clt;  // clear pc to clear vector
		logic jmp;  // pc = pc + 1 + b_im when true
		logic gto;  // pc = b_im when true
		pc_t  b_im;  // address or immediate
	} flow_ctl_t;

	// condition test for the slot at stage 0
	typedef struct packed {
		cond_e cond;
		data_t a;
		data_t b;
	} test_op_t;

endpackage

//--- source/thread_id_ring.sv
/*
	Thread ID ring
	Eight registers rotate the thread IDs so every stage of the
	barrel knows which thread it currently holds.
*/
`timescale 1ns/1ns

module thread_id_ring (
	input  logic                 clk_i,  // clock
	input  logic                 rst_i,  // async reset, active high
	output barrel_pkg::id_ring_t id_o  // id per stage
);

	import barrel_pkg::*;

	id_ring_t id_q;  // ring registers

	// stage k+1 takes stage k, stage 0 takes stage 7
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			id_q <= ID_RST;
		end else begin
			id_q <= {id_q[THREADS-2:0], id_q[THREADS-1]};
		end
	end

	assign id_o = id_q;

	// neighbouring stages differ by one thread, wrapping at 8
	a_id_step: assert property (
		@(posedge clk_i) disable iff (rst_i)
		id_q[1] == id_t'(id_q[0] + 1'b1)
	) else $error("thread id ring out of sequence");

endmodule

//--- source/cond_tester.sv
/*
	Condition tester
	Registers the stage-0 test, evaluates the condition in stage 1 and
	carries the result to stage 3 for the PC ring jump / goto mux.
*/
`timescale 1ns/1ns

module cond_tester (
	input  logic                 clk_i,  // clock
	input  logic                 rst_i,  // async reset, active high
	input  barrel_pkg::test_op_t test_i,  // condition & operands, stage 0
	output logic                 tst_res_3_o  // 1 : true for slot at stage 3
);

	import barrel_pkg::*;

	test_op_t op_1;  // test at stage 1
	logic     res_1;  // comb result, stage 1
	logic     res_2;
	logic     res_3;

	// 0:1 register
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			op_1 <= '0;
		end else begin
			op_1 <= test_i;
		end
	end

	// stage 1 compare
	always_comb begin
		unique case (op_1.cond)
			ALWAYS  : res_1 = 1'b1;  // jumps become unconditional
			ZERO    : res_1 = (op_1.a == '0);
			NZERO   : res_1 = (op_1.a != '0);
			NEG     : res_1 = op_1.a[DATA_W-1];  // sign bit
			LT      : res_1 = ($signed(op_1.a) < $signed(op_1.b));
			EQ      : res_1 = (op_1.a == op_1.b);
			default : res_1 = 1'b0;  // unused codes never true
		endcase
	end

	// 1:2 and 2:3 result pipe
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			res_2 <= 1'b0;
			res_3 <= 1'b0;
		end else begin
			res_2 <= res_1;
			res_3 <= res_2;
		end
	end

	assign tst_res_3_o = res_3;  // lines up with pc ring 3:4 mux

endmodule

//--- source/irq_latch.sv
/*
	Interrupt latch
	One pending bit per thread. Raises an interrupt for the slot at
	stage 0 when its thread is pending and not cleared, and drops the
	pending bit when the interrupt is served.
*/
`timescale 1ns/1ns

module irq_latch (
	input  logic                            clk_i,  // clock
	input  logic                            rst_i,  // async reset, active high
	input  logic [barrel_pkg::THREADS-1:0]  irq_req_i,  // request pulse per thread
	input  barrel_pkg::id_t                 id_0_i,  // thread at stage 0
	input  logic                            clt_i,  // 1 : stage 0 slot cleared
	output logic                            irq_o  // 1 : serve interrupt now
);

	import barrel_pkg::*;

	logic [THREADS-1:0] pend;  // pending per thread
	logic [THREADS-1:0] srv_mask;  // bit being served this cycle

	// clear wins over a pending interrupt, bit stays for a later trip
	assign irq_o = pend[id_0_i] & ~clt_i;

	always_comb begin
		srv_mask         = '0;
		srv_mask[id_0_i] = irq_o;
	end

	// new requests win over service in the same cycle
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			pend <= '0;
		end else begin
			pend <= (pend & ~srv_mask) | irq_req_i;
		end
	end

	a_no_irq_on_clt: assert property (
		@(posedge clk_i) disable iff (rst_i)
		!(irq_o && clt_i)
	) else $error("interrupt served on a cleared slot");

endmodule

//--- source/pc_ring.sv
/*
	PC ring
	Eight-stage PC generation and storage ring. Stage 0:1 does clear,
	interrupt hold or increment, 2:3 loads the interrupt vector, 3:4
	does jump / goto gated by the test result, 4 back to 0 just stores.
	Feedback from stage 0 into stage 1 keeps every thread's PC alive.
*/
`timescale 1ns/1ns

module pc_ring (
	input  logic                  clk_i,  // clock
	input  logic                  rst_i,  // async reset, active high
	input  barrel_pkg::id_ring_t  id_i,  // id per stage
	input  barrel_pkg::flow_ctl_t flow_i,  // flow command, stage 0
	input  logic                  irq_i,  // 1 : interrupt, stage 0
	input  logic                  tst_res_3_i,  // 1 : condition true, stage 3
	output barrel_pkg::pc_ring_t  pc_o  // pc per stage
);

	import barrel_pkg::*;

	// control riding along with the pc
	typedef struct packed {
		logic irq;
		logic jmp;
		logic gto;
		pc_t  b_im;
	} pipe_t;

	pc_t   pc_r [THREADS];  // ring registers
	pipe_t p_1;
	pipe_t p_2;
	pipe_t p_3;
	logic  kill_0;  // drop jump / goto for this slot

	function automatic pc_t clt_vec(input id_t id);
		return CLT_BASE + (pc_t'(id) << CLT_SPAN);
	endfunction

	function automatic pc_t irq_vec(input id_t id);
		return IRQ_BASE + (pc_t'(id) << IRQ_SPAN);
	endfunction

	assign kill_0 = flow_i.clt | irq_i;  // clear & interrupt override flow

	// 0:1 mux & register
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			p_1      <= '0;
			pc_r[1]  <= clt_vec(ID_RST[1]);
		end else begin
			p_1.irq  <= irq_i;
			p_1.gto  <= flow_i.gto & ~kill_0;
			p_1.jmp  <= flow_i.jmp & ~flow_i.gto & ~kill_0;  // goto has priority
			p_1.b_im <= flow_i.b_im;
			if (flow_i.clt) begin
				pc_r[1] <= clt_vec(id_i[0]);  // clear
			end else if (irq_i) begin
				pc_r[1] <= pc_r[0];  // hold, vector loaded at 3
			end else begin
				pc_r[1] <= pc_r[0] + 1'b1;  // inc for next
			end
		end
	end

	// 1:2 register
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			p_2     <= '0;
			pc_r[2] <= clt_vec(ID_RST[2]);
		end else begin
			p_2     <= p_1;
			pc_r[2] <= pc_r[1];
		end
	end

	// 2:3 mux & register
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			p_3     <= '0;
			pc_r[3] <= clt_vec(ID_RST[3]);
		end else begin
			p_3     <= p_2;
			if (p_2.irq) begin
				pc_r[3] <= irq_vec(id_i[2]);  // interrupt vector
			end else begin
				pc_r[3] <= pc_r[2];
			end
		end
	end

	// 3:4 mux & register
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			pc_r[4] <= clt_vec(ID_RST[4]);
		end else if (tst_res_3_i && p_3.gto) begin
			pc_r[4] <= p_3.b_im;  // goto
		end else if (tst_res_3_i && p_3.jmp) begin
			pc_r[4] <= pc_r[3] + p_3.b_im;  // jump, pc already +1
		end else begin
			pc_r[4] <= pc_r[3];
		end
	end

	// 4:0 storage
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			pc_r[5] <= clt_vec(ID_RST[5]);
			pc_r[6] <= clt_vec(ID_RST[6]);
			pc_r[7] <= clt_vec(ID_RST[7]);
			pc_r[0] <= clt_vec(ID_RST[0]);
		end else begin
			pc_r[5] <= pc_r[4];
			pc_r[6] <= pc_r[5];
			pc_r[7] <= pc_r[6];
			pc_r[0] <= pc_r[7];  // loops back into 0:1 mux
		end
	end

	always_comb begin
		for (int k = 0; k < THREADS; k++) begin
			pc_o[k] = pc_r[k];
		end
	end

	a_jg_excl: assert property (
		@(posedge clk_i) disable iff (rst_i)
		!(p_3.jmp && p_3.gto)
	) else $error("jump and goto both set at stage 3");

endmodule

//--- source/barrel_pc_top.sv
/*
	Barrel PC top
	Program-counter section of the eight-thread barrel processor.
	Ties the thread ID ring, condition tester, interrupt latch and PC ring.
*/
`timescale 1ns/1ns

module barrel_pc_top (
	input  logic                            clk_i,  // clock
	input  logic                            rst_i,  // async reset, active high
	input  barrel_pkg::flow_ctl_t           flow_i,  // flow command, stage 0
	input  barrel_pkg::test_op_t            test_i,  // condition test, stage 0
	input  logic [barrel_pkg::THREADS-1:0]  irq_req_i,  // request pulse per thread
	output barrel_pkg::id_ring_t            id_o,  // id per stage
	output barrel_pkg::pc_ring_t            pc_o  // pc per stage
);

	logic irq;  // serve interrupt, stage 0
	logic tst_res_3;  // condition result, stage 3

	thread_id_ring i_thread_id_ring (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.id_o  (id_o)
	);

	cond_tester i_cond_tester (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.test_i      (test_i),
		.tst_res_3_o (tst_res_3)
	);

	irq_latch i_irq_latch (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.irq_req_i (irq_req_i),
		.id_0_i    (id_o[0]),
		.clt_i     (flow_i.clt),  // never serve a cleared slot
		.irq_o     (irq)
	);

	pc_ring i_pc_ring (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.id_i        (id_o),
		.flow_i      (flow_i),
		.irq_i       (irq),
		.tst_res_3_i (tst_res_3),
		.pc_o        (pc_o)
	);

endmodule

//--- testbench/tb_pc_ref.svh
/*
	PC reference model
	Expected clear and interrupt vectors, branch condition result and
	next stage-0 PC of a thread slot, plus the Galois LFSR.
*/
`ifndef TB_PC_REF_SVH
`define TB_PC_REF_SVH

// 4k words per thread above the base
function automatic pc_t clear_vector(input id_t id);
	return CLT_BASE + pc_t'(id) * pc_t'(1 << CLT_SPAN);
endfunction

function automatic pc_t irq_vector(input id_t id);
	return IRQ_BASE + pc_t'(id) * pc_t'(1 << IRQ_SPAN);
endfunction

// true when the branch condition holds for the operands
function automatic logic cond_holds(input test_op_t x);
	logic r;
	case (x.cond)
		ALWAYS  : r = 1'b1;
		ZERO    : r = (x.a == 0);
		NZERO   : r = (x.a != 0);
		NEG     : r = ($signed(x.a) < 0);
		LT      : r = ((x.a ^ 16'h8000) < (x.b ^ 16'h8000));  // offset binary compare
		EQ      : r = (x.a == x.b);
		default : r = 1'b0;
	endcase
	return r;
endfunction

// pc the slot brings back to stage 0 one trip later
function automatic pc_t expect_next_pc(
	input pc_t       pc,
	input id_t       id,
	input flow_ctl_t f,
	input logic      irq,  // interrupt served in this slot
	input logic      ok  // condition result
);
	if (f.clt) begin
		return clear_vector(id);  // top priority
	end
	if (irq) begin
		return irq_vector(id);  // cancels jump and goto
	end
	if (f.gto) begin
		return ok ? f.b_im : pc_t'(pc + 1);  // goto request masks a jump
	end
	if (f.jmp && ok) begin
		return pc_t'(pc + 1 + f.b_im);
	end
	return pc_t'(pc + 1);
endfunction

// right shifting galois form, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

`endif

//--- testbench/tb_barrel_pc_top.sv
/*
	Barrel PC testbench
	Drives the PC section with directed and random flow commands,
	keeps an expected stage-0 PC and pending bit per thread and
	compares id and pc at stage 0 every cycle.
*/
`timescale 1ns/1ns

module tb_barrel_pc_top;

	import barrel_pkg::*;

	`include "tb_pc_ref.svh"

	localparam int LONG_CYCLES = 4000;  // random run length
	localparam int SLOT_WAIT   = 20;  // max cycles to reach a slot

	logic               clk_i;
	logic               rst_i;
	flow_ctl_t          flow_i;
	test_op_t           test_i;
	logic [THREADS-1:0] irq_req_i;
	id_ring_t           id_o;
	pc_ring_t           pc_o;

	pc_t                exp_pc [THREADS];  // expected pc at next stage-0 visit
	logic [THREADS-1:0] pend;  // expected pending interrupts
	logic [THREADS-1:0] srv_mask;
	logic               srv;
	id_t                model_id0;  // thread now at stage 0

	logic [31:0]        lfsr;
	string              cur_test;
	int                 err_cnt;
	int                 chk_cnt;
	int                 test_cnt;
	int                 err_base;
	int                 chk_base;
	logic               chk_en;
	cond_e              ce;
	flow_ctl_t          f;
	test_op_t           x;
	logic [THREADS-1:0] req;

	barrel_pc_top i_barrel_pc_top (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.flow_i    (flow_i),
		.test_i    (test_i),
		.irq_req_i (irq_req_i),
		.id_o      (id_o),
		.pc_o      (pc_o)
	);

	always #50 clk_i = ~clk_i;  // 100 ns period

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		chk_cnt++;
		assert (act === exp) else begin
			$display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
			err_cnt++;
		end
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		err_base = err_cnt;
		chk_base = chk_cnt;
	endtask

	task automatic finish_test();
		test_cnt++;
		$display("test %s: %0d checks, %0d errors", cur_test, chk_cnt - chk_base,
			err_cnt - err_base);
	endtask

	// returns at the negedge where thread t sits at stage 0
	task automatic wait_for_slot(input id_t t);
		int n;
		n = 0;
		do begin
			@(negedge clk_i);
			n++;
		end while (id_o[0] !== t && n < SLOT_WAIT);
		if (id_o[0] !== t) begin
			$display("timeout in %s: thread %0d never reached stage 0", cur_test, t);
			$display("Done: errors found");
			$finish;
		end
	endtask

	task automatic drive_idle();
		@(posedge clk_i);
		flow_i    <= '0;
		test_i    <= '{cond: ALWAYS, a: '0, b: '0};
		irq_req_i <= '0;
	endtask

	task automatic run_idle(input int n);
		for (int i = 0; i < n; i++) begin
			drive_idle();
		end
	endtask

	// one cycle of commands with random immediate and operands
	task automatic drive_cycle(input logic clt, input logic jmp, input logic gto,
		input cond_e c, input logic [THREADS-1:0] rq);
		pc_t   im;
		data_t a;
		data_t b;
		im = pc_t'(rand_bits(PC_W));
		a  = (rand_bits(2) == 0) ? data_t'(0) : data_t'(rand_bits(DATA_W));  // zero often
		b  = (rand_bits(2) == 0) ? a : data_t'(rand_bits(DATA_W));  // equal often
		@(posedge clk_i);
		flow_i    <= '{clt: clt, jmp: jmp, gto: gto, b_im: im};
		test_i    <= '{cond: c, a: a, b: b};
		irq_req_i <= rq;
	endtask

	// command sampled while thread t is at stage 0, thread t+1 comes just before
	task automatic drive_slot(input id_t t, input flow_ctl_t fc, input test_op_t tc);
		wait_for_slot(id_t'(t + 1'b1));
		@(posedge clk_i);
		flow_i <= fc;
		test_i <= tc;
		drive_idle();
	endtask

	task automatic pulse_irq(input logic [THREADS-1:0] mask);
		@(posedge clk_i);
		irq_req_i <= mask;
		drive_idle();
	endtask

	// expected model, steps with the slot sampled at stage 0
	always @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			for (int t = 0; t < THREADS; t++) begin
				exp_pc[t] = clear_vector(id_t'(t));
			end
			pend      = '0;
			model_id0 = '0;
		end else begin
			srv                = pend[model_id0] & ~flow_i.clt;  // clear keeps it pending
			exp_pc[model_id0]  = expect_next_pc(exp_pc[model_id0], model_id0, flow_i, srv,
				cond_holds(test_i));
			srv_mask            = '0;
			srv_mask[model_id0] = srv;
			pend               = (pend & ~srv_mask) | irq_req_i;  // request beats service
			model_id0          = model_id0 - 1'b1;  // stage 0 takes stage 7, ids count down
		end
	end

	// compare stage 0 against the model
	always @(negedge clk_i) begin
		if (chk_en && !rst_i) begin
			check_value("stage 0 id", model_id0, id_o[0]);
			check_value("stage 0 pc", exp_pc[model_id0], pc_o[0]);
		end
	end

	initial begin
		clk_i     = 1'b0;
		rst_i     = 1'b1;
		flow_i    = '0;
		test_i    = '{cond: ALWAYS, a: '0, b: '0};
		irq_req_i = '0;
		lfsr      = 32'ha449_43f0;
		err_cnt   = 0;
		chk_cnt   = 0;
		test_cnt  = 0;
		chk_en    = 1'b0;
		repeat (10) @(posedge clk_i);
		rst_i  <= 1'b0;
		chk_en = 1'b1;

		begin_test("reset_idle");
		@(negedge clk_i);
		for (int k = 0; k < THREADS; k++) begin
			check_value("reset id", k, id_o[k]);
			check_value("reset pc", clear_vector(id_t'(k)), pc_o[k]);
		end
		run_idle(32);  // four increments per thread
		finish_test();

		// pending interrupt and goto both lose to clear
		begin_test("clear");
		wait_for_slot(id_t'(1));
		pulse_irq(8'b0000_1000);
		f = '{clt: 1'b1, jmp: 1'b1, gto: 1'b1, b_im: 16'h1234};
		x = '{cond: ALWAYS, a: '0, b: '0};
		drive_slot(id_t'(3), f, x);
		wait_for_slot(id_t'(3));
		check_value("cleared pc", clear_vector(id_t'(3)), pc_o[0]);
		wait_for_slot(id_t'(3));  // still pending, served on this trip
		check_value("late irq pc", irq_vector(id_t'(3)), pc_o[0]);
		finish_test();

		begin_test("interrupt");
		wait_for_slot(id_t'(0));
		pulse_irq(8'b0010_0000);
		f = '{clt: 1'b0, jmp: 1'b1, gto: 1'b1, b_im: 16'h0bad};
		x = '{cond: ALWAYS, a: '0, b: '0};
		drive_slot(id_t'(5), f, x);
		wait_for_slot(id_t'(5));
		check_value("irq vector", irq_vector(id_t'(5)), pc_o[0]);
		wait_for_slot(id_t'(5));
		check_value("served once", irq_vector(id_t'(5)) + 1'b1, pc_o[0]);
		finish_test();

		// every slot jumps under one condition
		for (int c = 0; c < 6; c++) begin
			ce = cond_e'(c);
			begin_test($sformatf("jump_%s", ce.name()));
			for (int i = 0; i < 64; i++) begin
				drive_cycle(1'b0, 1'b1, 1'b0, ce, '0);
			end
			run_idle(8);  // let the last trip come back
			finish_test();
		end

		begin_test("goto");
		for (int i = 0; i < 96; i++) begin
			ce = cond_e'(rand_bits(8) % 6);
			drive_cycle(1'b0, 1'b0, 1'b1, ce, '0);
		end
		run_idle(8);
		finish_test();

		begin_test("random_mix");
		for (int i = 0; i < LONG_CYCLES; i++) begin
			for (int t = 0; t < THREADS; t++) begin
				req[t] = (rand_bits(6) == 0);  // rare per thread
			end
			ce = cond_e'(rand_bits(8) % 6);
			drive_cycle(rand_bits(5) == 0, rand_bits(2) == 0, rand_bits(2) == 0, ce, req);
		end
		run_idle(16);
		finish_test();

		$display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

//--- src.f
+incdir+testbench
source/barrel_pkg.sv
source/thread_id_ring.sv
source/cond_tester.sv
source/irq_latch.sv
source/pc_ring.sv
source/barrel_pc_top.sv
testbench/tb_barrel_pc_top.sv

//--- Bender.yml
package:
  name: barrel_pc

sources:
  - source/barrel_pkg.sv
  - source/thread_id_ring.sv
  - source/cond_tester.sv
  - source/irq_latch.sv
  - source/pc_ring.sv
  - source/barrel_pc_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_barrel_pc_top.sv
